// ==== logic/rv_cfg.svh ====
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// data path and address width
`define RV_XLEN 32

// architectural register count
`define RV_NREGS 32

// instruction memory depth in words
`define RV_IMEM_WORDS 256

// APB byte address width
`define RV_PADDR_W 12

// control and status word, first address past instruction memory
`define RV_CTRL_ADDR 12'h400

`endif

// ==== logic/rv_pkg.sv ====
`include "rv_cfg.svh"

package rv_pkg;

  // opcodes the core executes
  typedef enum logic [6:0] {
    OP_REG_IMM = 7'b0010011,
    OP_REG_REG = 7'b0110011,
    OP_LUI     = 7'b0110111,
    OP_BRANCH  = 7'b1100011,
    OP_ENV     = 7'b1110011
  } rv_opcode_e;

  // funct3 for ALU operations
  typedef enum logic [2:0] {
    F3_ADD  = 3'b000,
    F3_SLL  = 3'b001,
    F3_SLT  = 3'b010,
    F3_SLTU = 3'b011,
    F3_XOR  = 3'b100,
    F3_SRL  = 3'b101,
    F3_OR   = 3'b110,
    F3_AND  = 3'b111
  } rv_alu_f3_e;

  // funct3 for conditional branches
  typedef enum logic [2:0] {
    F3_BEQ  = 3'b000,
    F3_BNE  = 3'b001,
    F3_BLT  = 3'b100,
    F3_BGE  = 3'b101,
    F3_BLTU = 3'b110,
    F3_BGEU = 3'b111
  } rv_branch_f3_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    rv_opcode_e opcode;
  } rv_insn_r_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    rv_opcode_e  opcode;
  } rv_insn_i_t;

  // one instruction word, register and immediate formats
  typedef union packed {
    rv_insn_r_t r;
    rv_insn_i_t i;
  } rv_insn_u;

  typedef struct packed {
    logic [`RV_XLEN-1:0] pc;
    rv_insn_u            insn;
    logic                valid;
  } fetch_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0] pc;
    rv_insn_u            insn;
    logic [`RV_XLEN-1:0] rs1_val;
    logic [`RV_XLEN-1:0] rs2_val;
    logic [`RV_XLEN-1:0] imm;
    logic                valid;
  } decode_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0] pc;
    rv_insn_u            insn;
    logic [4:0]          rd;
    logic                wr_en;
    logic [`RV_XLEN-1:0] result;
    logic                ecall;
    logic                valid;
  } result_t;

  typedef struct packed {
    logic                valid;
    logic [`RV_XLEN-1:0] target;
  } redirect_t;

  typedef struct packed {
    logic                valid;
    logic [`RV_XLEN-1:0] pc;
    rv_insn_u            insn;
    logic [4:0]          rd;
    logic                wr_en;
    logic [`RV_XLEN-1:0] data;
  } retire_t;

  typedef struct packed {
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`RV_PADDR_W-1:0] paddr;
    logic [`RV_XLEN-1:0]    pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0] prdata;
    logic                pready;
    logic                pslverr;
  } apb_rsp_t;

endpackage

// ==== logic/imem_apb.sv ====
`timescale 1ns/1ps
`include "rv_cfg.svh"

module imem_apb import rv_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  apb_req_t            apb_req,
  output apb_rsp_t            apb_rsp,
  input  logic [`RV_XLEN-1:0] pc,
  output rv_insn_u            insn,
  output logic                run,
  input  logic                halt
);

  localparam int IDX_W = $clog2(`RV_IMEM_WORDS);

  logic [`RV_XLEN-1:0] mem [`RV_IMEM_WORDS];

  logic             access;
  logic             in_mem;
  logic             is_ctrl;
  logic [IDX_W-1:0] apb_idx;
  logic [IDX_W-1:0] pc_idx;

  // access phase of a transfer
  assign access  = apb_req.psel & apb_req.penable;

  // word-aligned addresses below the control word hit the memory
  assign in_mem  = (apb_req.paddr < `RV_CTRL_ADDR) && (apb_req.paddr[1:0] == 2'b00);
  assign is_ctrl = (apb_req.paddr == `RV_CTRL_ADDR);
  assign apb_idx = apb_req.paddr[IDX_W+1:2];
  assign pc_idx  = pc[IDX_W+1:2];

  // fetch port, combinational read at the pc
  assign insn = mem[pc_idx];

  always_ff @(posedge clk) begin
    if (access && apb_req.pwrite && in_mem) begin
      mem[apb_idx] <= apb_req.pwdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      run <= 1'b0;
    end else if (access && apb_req.pwrite && is_ctrl) begin
      run <= apb_req.pwdata[0];
    end
  end

  always_comb begin
    apb_rsp.prdata = '0;
    if (in_mem) begin
      apb_rsp.prdata = mem[apb_idx];
    end else if (is_ctrl) begin
      // status word: run in bit 0, halt in bit 1
      apb_rsp.prdata = {{(`RV_XLEN-2){1'b0}}, halt, run};
    end
  end

  // no wait states
  assign apb_rsp.pready  = 1'b1;
  assign apb_rsp.pslverr = access & ~(in_mem | is_ctrl);

endmodule

// ==== logic/rv_fetch.sv ====
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_fetch import rv_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  logic                run,
  input  rv_insn_u            insn,
  input  redirect_t           redirect,
  output logic [`RV_XLEN-1:0] pc,
  output fetch_t              fetched
);

  // program counter, a taken branch wins over sequential fetch
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (redirect.valid) begin
      pc <= redirect.target;
    end else if (run) begin
      pc <= pc + `RV_XLEN'd4;
    end
  end

  // fetch-to-decode register
  always_ff @(posedge clk) begin
    fetched <= '{
      pc:    pc,
      insn:  insn,
      valid: run & ~redirect.valid
    };
    if (rst) begin
      fetched.valid <= 1'b0;
    end
  end

endmodule

// ==== logic/rv_regfile.sv ====
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_regfile (
  input  logic                clk,
  input  logic                rst,
  input  logic [4:0]          rs1,
  input  logic [4:0]          rs2,
  output logic [`RV_XLEN-1:0] rs1_data,
  output logic [`RV_XLEN-1:0] rs2_data,
  input  logic                wr_en,
  input  logic [4:0]          wr_idx,
  input  logic [`RV_XLEN-1:0] wr_data
);

  logic [`RV_XLEN-1:0] regs [`RV_NREGS];
  logic                wr_live;

  // x0 is never written
  assign wr_live = wr_en && (wr_idx != 5'd0);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_live) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // write-through covers a read in the same cycle as writeback
  assign rs1_data = (wr_live && wr_idx == rs1) ? wr_data : regs[rs1];
  assign rs2_data = (wr_live && wr_idx == rs2) ? wr_data : regs[rs2];

endmodule

// ==== logic/rv_decode.sv ====
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_decode import rv_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  fetch_t              fetched,
  input  redirect_t           redirect,
  output logic [4:0]          rs1,
  output logic [4:0]          rs2,
  input  logic [`RV_XLEN-1:0] rs1_data,
  input  logic [`RV_XLEN-1:0] rs2_data,
  output decode_t             decoded
);

  rv_insn_u            d_insn;
  logic [`RV_XLEN-1:0] imm_i_sext;
  logic [`RV_XLEN-1:0] imm_i_zext;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] imm;

  assign d_insn = fetched.insn;

  // register read indices come from the r view
  assign rs1 = d_insn.r.rs1;
  assign rs2 = d_insn.r.rs2;

  assign imm_i_sext = {{(`RV_XLEN-12){d_insn.i.imm[11]}}, d_insn.i.imm};
  assign imm_i_zext = {{(`RV_XLEN-12){1'b0}}, d_insn.i.imm};

  // branch offset scattered over funct7 and rd
  assign imm_b = {{(`RV_XLEN-12){d_insn.r.funct7[6]}}, d_insn.r.rd[0],
                  d_insn.r.funct7[5:0], d_insn.r.rd[4:1], 1'b0};

  // upper 20 bits, shifted into place in execute
  assign imm_u = {{(`RV_XLEN-20){1'b0}}, d_insn.i.imm, d_insn.i.rs1, d_insn.i.funct3};

  always_comb begin
    case (d_insn.i.opcode)
      OP_REG_IMM: begin
        if (d_insn.i.funct3 inside {F3_SLTU, F3_SLL, F3_SRL}) begin
          imm = imm_i_zext;
        end else begin
          imm = imm_i_sext;
        end
      end
      OP_BRANCH: imm = imm_b;
      OP_LUI:    imm = imm_u;
      default:   imm = '0;
    endcase
  end

  // decode-to-execute register, squashed by a taken branch
  always_ff @(posedge clk) begin
    decoded <= '{
      pc:      fetched.pc,
      insn:    fetched.insn,
      rs1_val: rs1_data,
      rs2_val: rs2_data,
      imm:     imm,
      valid:   fetched.valid & ~redirect.valid
    };
    if (rst) begin
      decoded.valid <= 1'b0;
    end
  end

endmodule

// ==== logic/rv_execute.sv ====
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_execute import rv_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  decode_t   decoded,
  input  result_t   mem_stage,
  input  result_t   wb_stage,
  output redirect_t redirect,
  output result_t   executed
);

  // memory stage is younger, so it is checked first
  function automatic logic [`RV_XLEN-1:0] fwd_operand(
    input logic [4:0]          idx,
    input logic [`RV_XLEN-1:0] reg_val,
    input result_t             mem_s,
    input result_t             wb_s
  );
    logic [`RV_XLEN-1:0] val;
    val = reg_val;
    if (idx != 5'd0 && mem_s.valid && mem_s.wr_en && mem_s.rd == idx) begin
      val = mem_s.result;
    end else if (idx != 5'd0 && wb_s.valid && wb_s.wr_en && wb_s.rd == idx) begin
      val = wb_s.result;
    end
    return val;
  endfunction

  rv_insn_u            x_insn;
  logic [`RV_XLEN-1:0] op_a;
  logic [`RV_XLEN-1:0] op_b;
  logic [`RV_XLEN-1:0] alu_b;
  logic [`RV_XLEN-1:0] alu_out;
  logic [`RV_XLEN-1:0] result;
  logic                is_rr;
  logic                alt;
  logic                writes;
  logic                take;

  assign x_insn = decoded.insn;
  assign op_a   = fwd_operand(x_insn.r.rs1, decoded.rs1_val, mem_stage, wb_stage);
  assign op_b   = fwd_operand(x_insn.r.rs2, decoded.rs2_val, mem_stage, wb_stage);
  assign is_rr  = (x_insn.r.opcode == OP_REG_REG);
  assign alu_b  = is_rr ? op_b : decoded.imm;

  // funct7 bit 5 selects sub and arithmetic shift
  assign alt = x_insn.r.funct7[5];

  always_comb begin
    case (x_insn.r.funct3)
      F3_ADD:  alu_out = (is_rr && alt) ? op_a - alu_b : op_a + alu_b;
      F3_SLL:  alu_out = op_a << alu_b[4:0];
      F3_SLT:  alu_out = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
      F3_SLTU: alu_out = {{(`RV_XLEN-1){1'b0}}, op_a < alu_b};
      F3_XOR:  alu_out = op_a ^ alu_b;
      F3_SRL:  alu_out = alt ? `RV_XLEN'($signed(op_a) >>> alu_b[4:0]) : op_a >> alu_b[4:0];
      F3_OR:   alu_out = op_a | alu_b;
      default: alu_out = op_a & alu_b;
    endcase
  end

  always_comb begin
    case (x_insn.r.funct3)
      F3_BEQ:  take = (op_a == op_b);
      F3_BNE:  take = (op_a != op_b);
      F3_BLT:  take = ($signed(op_a) < $signed(op_b));
      F3_BGE:  take = ($signed(op_a) >= $signed(op_b));
      F3_BLTU: take = (op_a < op_b);
      F3_BGEU: take = (op_a >= op_b);
      default: take = 1'b0;
    endcase
  end

  assign redirect.valid  = decoded.valid && (x_insn.r.opcode == OP_BRANCH) && take;
  assign redirect.target = decoded.pc + decoded.imm;

  assign writes = x_insn.r.opcode inside {OP_REG_IMM, OP_REG_REG, OP_LUI};
  assign result = (x_insn.r.opcode == OP_LUI) ? decoded.imm << 12 : alu_out;

  // execute-to-memory register
  always_ff @(posedge clk) begin
    executed <= '{
      pc:     decoded.pc,
      insn:   decoded.insn,
      rd:     x_insn.r.rd,
      wr_en:  writes && (x_insn.r.rd != 5'd0),
      result: result,
      ecall:  (x_insn.i.opcode == OP_ENV) && (x_insn.i.imm == 12'd0),
      valid:  decoded.valid
    };
    if (rst) begin
      executed.valid <= 1'b0;
    end
  end

endmodule

// ==== logic/rv_retire.sv ====
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_retire import rv_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  result_t             executed,
  output result_t             mem_stage,
  output result_t             wb_stage,
  output logic                wr_en,
  output logic [4:0]          wr_idx,
  output logic [`RV_XLEN-1:0] wr_data,
  output retire_t             retire,
  output logic                halt
);

  logic retire_ok;

  // no loads, so the memory stage is the execute register itself
  assign mem_stage = executed;

  // memory-to-writeback register
  always_ff @(posedge clk) begin
    wb_stage <= mem_stage;
    if (rst) begin
      wb_stage.valid <= 1'b0;
    end
  end

  // nothing retires once halted
  assign retire_ok = wb_stage.valid & ~halt;

  assign wr_en   = retire_ok & wb_stage.wr_en;
  assign wr_idx  = wb_stage.rd;
  assign wr_data = wb_stage.result;

  // report lands on the same edge as the register write
  always_ff @(posedge clk) begin
    retire <= '{
      valid: retire_ok,
      pc:    wb_stage.pc,
      insn:  wb_stage.insn,
      rd:    wb_stage.rd,
      wr_en: wb_stage.wr_en,
      data:  wb_stage.result
    };
    if (rst) begin
      retire.valid <= 1'b0;
    end
  end

  // sticky until reset
  always_ff @(posedge clk) begin
    if (rst) begin
      halt <= 1'b0;
    end else if (wb_stage.valid && wb_stage.ecall) begin
      halt <= 1'b1;
    end
  end

endmodule

// ==== logic/rv_top.sv ====
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_top import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  apb_req_t apb_req,
  output apb_rsp_t apb_rsp,
  output retire_t  retire,
  output logic     halt
);

  logic [`RV_XLEN-1:0] pc;
  rv_insn_u            insn;
  logic                run;
  fetch_t              fetched;
  decode_t             decoded;
  result_t             executed;
  result_t             mem_stage;
  result_t             wb_stage;
  redirect_t           redirect;
  logic [4:0]          rs1;
  logic [4:0]          rs2;
  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] rs2_data;
  logic                wr_en;
  logic [4:0]          wr_idx;
  logic [`RV_XLEN-1:0] wr_data;

  imem_apb u_imem (
    .clk(clk), .rst(rst), .apb_req(apb_req), .apb_rsp(apb_rsp),
    .pc(pc), .insn(insn), .run(run), .halt(halt)
  );

  rv_fetch u_fetch (
    .clk(clk), .rst(rst), .run(run), .insn(insn), .redirect(redirect),
    .pc(pc), .fetched(fetched)
  );

  rv_regfile u_regfile (
    .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data)
  );

  rv_decode u_decode (
    .clk(clk), .rst(rst), .fetched(fetched), .redirect(redirect), .rs1(rs1), .rs2(rs2),
    .rs1_data(rs1_data), .rs2_data(rs2_data), .decoded(decoded)
  );

  rv_execute u_execute (
    .clk(clk), .rst(rst), .decoded(decoded), .mem_stage(mem_stage), .wb_stage(wb_stage),
    .redirect(redirect), .executed(executed)
  );

  rv_retire u_retire (
    .clk(clk), .rst(rst), .executed(executed), .mem_stage(mem_stage), .wb_stage(wb_stage),
    .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data), .retire(retire), .halt(halt)
  );

endmodule

// ==== test/rv_assertions.sv ====
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_assertions import rv_pkg::*; (
  input logic     clk,
  input logic     rst,
  input apb_req_t apb_req,
  input apb_rsp_t apb_rsp,
  input retire_t  retire,
  input logic     halt
);

  localparam int XL = `RV_XLEN;

  int unsigned fail_count = 0;

  // architectural state rebuilt from the retired instruction stream
  logic [XL-1:0] shadow [`RV_NREGS];
  logic [XL-1:0] next_pc;
  logic          seen_ecall;
  logic          exp_run;

  logic [31:0]   w;
  logic [6:0]    op;
  logic [4:0]    rd_f;
  logic [XL-1:0] src1;
  logic [XL-1:0] src2;
  logic [XL-1:0] exp_data;
  logic [XL-1:0] br_target;
  logic [XL-1:0] exp_status;
  logic          is_alu;
  logic          is_branch;
  logic          is_ecall;
  logic          br_taken;
  logic          access;
  logic          mapped;

  // differing signs decide alone, else an unsigned compare
  function automatic logic lt_signed(input logic [XL-1:0] a, input logic [XL-1:0] b);
    logic res;
    if (a[XL-1] != b[XL-1]) begin
      res = a[XL-1];
    end else begin
      res = (a < b);
    end
    return res;
  endfunction

  // RV32I result of an ALU or lui instruction
  function automatic logic [XL-1:0] isa_result(
    input logic [31:0]   insn,
    input logic [XL-1:0] a,
    input logic [XL-1:0] b
  );
    logic [XL-1:0] opnd;
    logic [XL-1:0] fill;
    logic [XL-1:0] res;
    logic [4:0]    sh;
    if (insn[6:0] == 7'b0110011) begin
      opnd = b;
    end else begin
      opnd = {{20{insn[31]}}, insn[31:20]};
    end
    sh = opnd[4:0];
    // sign bits shifted in by sra and srai
    fill = (insn[30] && a[XL-1]) ? ~({XL{1'b1}} >> sh) : '0;
    case (insn[14:12])
      3'b000: res = (insn[6:0] == 7'b0110011 && insn[30]) ? a - opnd : a + opnd;
      3'b001: res = a << sh;
      3'b010: res = {31'd0, lt_signed(a, opnd)};
      3'b011: res = {31'd0, a < opnd};
      3'b100: res = a ^ opnd;
      3'b101: res = (a >> sh) | fill;
      3'b110: res = a | opnd;
      default: res = a & opnd;
    endcase
    if (insn[6:0] == 7'b0110111) begin
      res = {insn[31:12], 12'h000};
    end
    return res;
  endfunction

  function automatic logic branch_holds(
    input logic [2:0]    f3,
    input logic [XL-1:0] a,
    input logic [XL-1:0] b
  );
    logic t;
    case (f3)
      3'b000: t = (a == b);
      3'b001: t = (a != b);
      3'b100: t = lt_signed(a, b);
      3'b101: t = !lt_signed(a, b);
      3'b110: t = (a < b);
      3'b111: t = !(a < b);
      default: t = 1'b0;
    endcase
    return t;
  endfunction

  assign w         = retire.insn;
  assign op        = w[6:0];
  assign rd_f      = w[11:7];
  assign src1      = shadow[w[19:15]];
  assign src2      = shadow[w[24:20]];
  assign is_alu    = op inside {7'b0010011, 7'b0110011, 7'b0110111};
  assign is_branch = (op == 7'b1100011);
  assign is_ecall  = (w == 32'h0000_0073);
  assign exp_data  = isa_result(w, src1, src2);
  assign br_taken  = is_branch && branch_holds(w[14:12], src1, src2);
  assign br_target = retire.pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};

  // status word: run in bit 0, halt in bit 1, zero above
  assign exp_status = {{(XL-2){1'b0}}, seen_ecall, exp_run};

  assign access = apb_req.psel && apb_req.penable;
  assign mapped = (apb_req.paddr == `RV_CTRL_ADDR) ||
                  (apb_req.paddr[1:0] == 2'b00 && int'(apb_req.paddr) < 4 * `RV_IMEM_WORDS);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        shadow[i] <= '0;
      end
      next_pc    <= '0;
      seen_ecall <= 1'b0;
      exp_run    <= 1'b0;
    end else begin
      if (retire.valid) begin
        if (is_alu && rd_f != 5'd0) begin
          shadow[rd_f] <= exp_data;
        end
        next_pc <= br_taken ? br_target : retire.pc + 32'd4;
        if (is_ecall) begin
          seen_ecall <= 1'b1;
        end
      end
      if (access && apb_req.pwrite && apb_req.paddr == `RV_CTRL_ADDR) begin
        exp_run <= apb_req.pwdata[0];
      end
    end
  end

  a_alu_result: assert property (@(posedge clk) disable iff (rst)
    retire.valid && is_alu |-> retire.data == exp_data)
    else begin
      fail_count++;
      $error("ERR %0t retire.data got %h expected %h", $time,
             $sampled(retire.data), $sampled(exp_data));
    end

  a_alu_dest: assert property (@(posedge clk) disable iff (rst)
    retire.valid && is_alu && rd_f != 5'd0 |-> retire.wr_en && retire.rd == rd_f)
    else begin
      fail_count++;
      $error("ERR %0t retire.rd got %0d expected %0d", $time, $sampled(retire.rd), $sampled(rd_f));
    end

  a_next_pc: assert property (@(posedge clk) disable iff (rst)
    retire.valid |-> retire.pc == next_pc)
    else begin
      fail_count++;
      $error("ERR %0t retire.pc got %h expected %h", $time, $sampled(retire.pc), $sampled(next_pc));
    end

  a_no_x0: assert property (@(posedge clk) disable iff (rst)
    retire.valid && retire.wr_en |-> retire.rd != 5'd0)
    else begin
      fail_count++;
      $error("a retired instruction wrote register x0");
    end

  a_ctl_no_write: assert property (@(posedge clk) disable iff (rst)
    retire.valid && (is_branch || is_ecall) |-> !retire.wr_en)
    else begin
      fail_count++;
      $error("a branch or ecall retired with a register write");
    end

  a_halt_on_ecall: assert property (@(posedge clk) disable iff (rst)
    retire.valid && is_ecall |-> halt)
    else begin
      fail_count++;
      $error("halt is low although an ecall retired");
    end

  a_halt_held: assert property (@(posedge clk) disable iff (rst)
    seen_ecall |-> halt)
    else begin
      fail_count++;
      $error("halt fell after an ecall had retired");
    end

  a_quiet_after_halt: assert property (@(posedge clk) disable iff (rst)
    seen_ecall |-> !retire.valid)
    else begin
      fail_count++;
      $error("an instruction retired after the core halted");
    end

  a_status: assert property (@(posedge clk) disable iff (rst)
    access && !apb_req.pwrite && apb_req.paddr == `RV_CTRL_ADDR |->
      apb_rsp.prdata == exp_status)
    else begin
      fail_count++;
      $error("ERR %0t apb_rsp.prdata got %h expected %h", $time,
             $sampled(apb_rsp.prdata), $sampled(exp_status));
    end

  a_slverr: assert property (@(posedge clk) disable iff (rst)
    access |-> apb_rsp.pslverr == !mapped)
    else begin
      fail_count++;
      $error("ERR %0t apb_rsp.pslverr got %b expected %b", $time,
             $sampled(apb_rsp.pslverr), $sampled(!mapped));
    end

  a_pready: assert property (@(posedge clk) disable iff (rst)
    access |-> apb_rsp.pready)
    else begin
      fail_count++;
      $error("pready is low in an APB access phase");
    end

endmodule

// ==== test/rv_tb.sv ====
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_tb import rv_pkg::*; ();

  localparam int HALT_LIMIT = 2000;
  localparam int APB_LIMIT  = 16;

  logic     clk;
  logic     rst;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;
  retire_t  retire;
  logic     halt;

  logic [31:0] prog [$];
  logic [31:0] rd_word;
  int unsigned wait_errors;
  int unsigned seed_val;
  int          cycles;

  rv_top DUT (
    .clk(clk), .rst(rst), .apb_req(apb_req), .apb_rsp(apb_rsp),
    .retire(retire), .halt(halt)
  );

  bind rv_top rv_assertions chk (
    .clk(clk), .rst(rst), .apb_req(apb_req), .apb_rsp(apb_rsp),
    .retire(retire), .halt(halt)
  );

  function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] b_word(input logic [12:0] off, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'b0110111};
  endfunction

  // branch over one filler, so a taken branch lands at pc + 8
  task automatic add_branch(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2);
    prog.push_back(b_word(13'd8, rs2, rs1, f3));
    prog.push_back(i_word(12'd1, 5'd25, 3'b000, 5'd25));
  endtask

  task automatic build_program();
    // dependent chain, distances 1 to 3 hit mem, wb and write-through
    prog.push_back(lui_word(20'($urandom), 5'd1));
    prog.push_back(i_word(12'($urandom), 5'd1, 3'b000, 5'd1));
    prog.push_back(i_word(12'($urandom), 5'd0, 3'b000, 5'd2));
    prog.push_back(r_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
    prog.push_back(r_word(7'h20, 5'd1, 5'd3, 3'b000, 5'd4));
    prog.push_back(r_word(7'h00, 5'd2, 5'd4, 3'b001, 5'd5));
    prog.push_back(r_word(7'h00, 5'd3, 5'd4, 3'b010, 5'd6));
    prog.push_back(r_word(7'h00, 5'd3, 5'd4, 3'b011, 5'd7));
    prog.push_back(r_word(7'h00, 5'd6, 5'd5, 3'b100, 5'd8));
    prog.push_back(r_word(7'h00, 5'd2, 5'd8, 3'b101, 5'd9));
    prog.push_back(r_word(7'h20, 5'd2, 5'd1, 3'b101, 5'd10));
    prog.push_back(r_word(7'h00, 5'd10, 5'd9, 3'b110, 5'd11));
    prog.push_back(r_word(7'h00, 5'd1, 5'd11, 3'b111, 5'd12));
    prog.push_back(i_word(12'($urandom), 5'd12, 3'b010, 5'd13));
    // sltiu immediate kept non-negative
    prog.push_back(i_word({1'b0, 11'($urandom)}, 5'd12, 3'b011, 5'd14));
    prog.push_back(i_word(12'($urandom), 5'd14, 3'b100, 5'd15));
    prog.push_back(i_word(12'($urandom), 5'd15, 3'b110, 5'd16));
    prog.push_back(i_word(12'($urandom), 5'd16, 3'b111, 5'd17));
    prog.push_back(i_word({7'h00, 5'($urandom)}, 5'd17, 3'b001, 5'd18));
    prog.push_back(i_word({7'h00, 5'($urandom)}, 5'd18, 3'b101, 5'd19));
    prog.push_back(i_word({7'h20, 5'($urandom)}, 5'd1, 3'b101, 5'd20));
    // write aimed at x0, then a read of x0
    prog.push_back(i_word(12'd123, 5'd5, 3'b000, 5'd0));
    prog.push_back(r_word(7'h00, 5'd5, 5'd0, 3'b000, 5'd21));
    // x22 = -5 and x23 = 7 order differently signed and unsigned
    prog.push_back(i_word(12'hffb, 5'd0, 3'b000, 5'd22));
    prog.push_back(i_word(12'd7, 5'd0, 3'b000, 5'd23));
    add_branch(3'b000, 5'd23, 5'd23);
    add_branch(3'b000, 5'd22, 5'd23);
    add_branch(3'b001, 5'd22, 5'd23);
    add_branch(3'b001, 5'd23, 5'd23);
    add_branch(3'b100, 5'd22, 5'd23);
    add_branch(3'b100, 5'd23, 5'd22);
    add_branch(3'b101, 5'd23, 5'd22);
    add_branch(3'b101, 5'd22, 5'd23);
    add_branch(3'b110, 5'd23, 5'd22);
    add_branch(3'b110, 5'd22, 5'd23);
    add_branch(3'b111, 5'd22, 5'd23);
    add_branch(3'b111, 5'd23, 5'd22);
    prog.push_back(32'h0000_0073);
    // in flight behind the ecall, never retired
    for (int i = 0; i < 3; i++) begin
      prog.push_back(i_word(12'd1, 5'd26, 3'b000, 5'd26));
    end
  endtask

  // setup phase, then access phase until pready
  task automatic apb_transfer(input logic wr, input logic [11:0] addr, input logic [31:0] data,
                              output logic [31:0] rdata);
    int n;
    @(negedge clk);
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: data};
    @(negedge clk);
    apb_req.penable = 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!apb_rsp.pready && n < APB_LIMIT);
    if (!apb_rsp.pready) begin
      $display("APB transfer to address %h never completed", addr);
      wait_errors++;
    end
    rdata = apb_rsp.prdata;
    @(negedge clk);
    apb_req = '0;
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    seed_val = $urandom(67);
    rst = 1'b1;
    apb_req = '0;
    wait_errors = 0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    build_program();
    foreach (prog[i]) begin
      apb_transfer(1'b1, 12'(4 * i), prog[i], rd_word);
    end
    apb_transfer(1'b0, `RV_CTRL_ADDR, '0, rd_word);
    apb_transfer(1'b1, `RV_CTRL_ADDR, 32'd1, rd_word);

    cycles = 0;
    while (!halt && cycles < HALT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!halt) begin
      $display("the core never halted within %0d cycles", HALT_LIMIT);
      wait_errors++;
    end

    // idle window for the quiet-after-halt check
    repeat (8) @(negedge clk);
    apb_transfer(1'b0, `RV_CTRL_ADDR, '0, rd_word);
    $display("status word after halt: %h", rd_word);
    apb_transfer(1'b1, `RV_CTRL_ADDR, 32'd0, rd_word);
    apb_transfer(1'b0, `RV_CTRL_ADDR, '0, rd_word);
    apb_transfer(1'b0, 12'h404, '0, rd_word);
    apb_transfer(1'b1, 12'h006, 32'hdead_beef, rd_word);
    apb_transfer(1'b0, 12'h008, '0, rd_word);

    $display("assertion failures: %0d, wait timeouts: %0d", DUT.chk.fail_count, wait_errors);
    if (DUT.chk.fail_count == 0 && wait_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+logic
logic/rv_pkg.sv
logic/imem_apb.sv
logic/rv_fetch.sv
logic/rv_regfile.sv
logic/rv_decode.sv
logic/rv_execute.sv
logic/rv_retire.sv
logic/rv_top.sv
test/rv_assertions.sv
test/rv_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the rv_top testbench with Verilator, verdict from sim.log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module rv_tb -Mdir obj_dir -o rv_sim &&
./obj_dir/rv_sim +verilator+error+limit+1000 > sim.log 2>&1 &&
! grep -q "ERRORS FOUND" sim.log &&
echo "simulation passed" || { echo "simulation failed, see sim.log"; exit 1; }
